/* filelist.f */
src/hough_pkg.sv
src/accum_bus_if.sv
src/edge_frame_store.sv
src/hough_voter.sv
src/line_picker.sv
src/accum_arbiter.sv
src/hough_top.sv
dv/hough_tb_sva.sv
dv/hough_tb.sv

/* Bender.yml */
package:
  name: hough_lane_finder

sources:
  - src/hough_pkg.sv
  - src/accum_bus_if.sv
  - src/edge_frame_store.sv
  - src/hough_voter.sv
  - src/line_picker.sv
  - src/accum_arbiter.sv
  - src/hough_top.sv
  - target: simulation
    files:
      - dv/hough_tb_sva.sv
      - dv/hough_tb.sv

/* dv/hough_tb.sv */
// Hough lane finder testbench with directed frames, a reference model and a watchdog
module hough_tb
    import hough_pkg::*;
();

    localparam int CLK_PERIOD    = 40;
    localparam int FRAME_BOUND   = PIXELS * THETAS * 8 + ACC_DEPTH * 8;
    localparam int NUM_FRAMES    = 9;
    localparam int WATCHDOG_TIME = NUM_FRAMES * FRAME_BOUND * CLK_PERIOD;

    logic                  clock;
    logic                  reset;
    logic                  pixel_wr_en;
    logic [7:0]            pixel_din;
    logic [7:0]            mask_din;
    logic                  pixel_full;
    logic                  frame_done;
    logic                  left_valid;
    logic [THETA_BITS-1:0] left_theta;
    logic signed [6:0]     left_rho;
    logic [COUNT_BITS-1:0] left_votes;
    logic                  right_valid;
    logic [THETA_BITS-1:0] right_theta;
    logic signed [6:0]     right_rho;
    logic [COUNT_BITS-1:0] right_votes;

    // Frame under test and expected results, index 0 left and 1 right
    logic [7:0]            pix_mem   [PIXELS];
    logic [7:0]            mask_mem  [PIXELS];
    logic                  exp_valid [2];
    logic [THETA_BITS-1:0] exp_theta [2];
    logic signed [6:0]     exp_rho   [2];
    logic [COUNT_BITS-1:0] exp_votes [2];
    logic [31:0]           lfsr_state;

    hough_top dut0 (.*);

    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_fail($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_theta(input string name, input logic [THETA_BITS-1:0] got,
                               input logic [THETA_BITS-1:0] exp);
        if (got !== exp) begin
            report_fail($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_rho(input string name, input logic signed [6:0] got,
                             input logic signed [6:0] exp);
        if (got !== exp) begin
            report_fail($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input logic [COUNT_BITS-1:0] got,
                               input logic [COUNT_BITS-1:0] exp);
        if (got !== exp) begin
            report_fail($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // Galois LFSR, one step per bit taken
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[6:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
        end
        return r;
    endfunction

    // Expected accumulator built from the edge and rho rules, then the best bin per half
    function automatic void model_frame();
        int acc [ACC_DEPTH];
        int sum;
        int addr;
        int h;
        int best_bin [2];
        int best_cnt [2];
        int best_t   [2];
        for (int a = 0; a < ACC_DEPTH; a++) begin
            acc[a] = 0;
        end
        for (int p = 0; p < PIXELS; p++) begin
            if (pix_mem[p] >= EDGE_THRESHOLD && mask_mem[p] != 8'h00) begin
                for (int t = 0; t < THETAS; t++) begin
                    sum  = (p % IMG_W) * int'(COS_TABLE[t]) + (p / IMG_W) * int'(SIN_TABLE[t]);
                    addr = t * RHO_BINS + (sum >>> 8) + RHO_OFFSET;
                    if (acc[addr] < 255) begin
                        acc[addr]++;
                    end
                end
            end
        end
        best_cnt = '{0, 0};
        best_bin = '{0, 0};
        best_t   = '{0, LEFT_THETAS};
        for (int t = 0; t < THETAS; t++) begin
            for (int b = 0; b < RHO_BINS; b++) begin
                h = (t >= LEFT_THETAS) ? 1 : 0;
                if (acc[t * RHO_BINS + b] > best_cnt[h]) begin
                    best_cnt[h] = acc[t * RHO_BINS + b];
                    best_bin[h] = b;
                    best_t[h]   = t;
                end
            end
        end
        for (int i = 0; i < 2; i++) begin
            exp_valid[i] = (best_cnt[i] >= VOTE_THRESHOLD);
            exp_theta[i] = THETA_BITS'(best_t[i]);
            exp_rho[i]   = 7'(best_bin[i] - RHO_OFFSET);
            exp_votes[i] = COUNT_BITS'(best_cnt[i]);
        end
    endfunction

    task automatic fill_frame(input logic [7:0] strength, input logic [7:0] mask);
        for (int p = 0; p < PIXELS; p++) begin
            pix_mem[p]  = strength;
            mask_mem[p] = mask;
        end
    endtask

    task automatic set_pixel(input int x, input int y, input logic [7:0] s, input logic [7:0] m);
        pix_mem[y * IMG_W + x]  = s;
        mask_mem[y * IMG_W + x] = m;
    endtask

    // Streams the frame; with hold set, wr_en stays high on strong junk while the store is full
    task automatic send_frame(input logic hold);
        for (int i = 0; i < PIXELS; i++) begin
            @(negedge clock);
            while (pixel_full) begin
                pixel_wr_en = hold;
                pixel_din   = 8'hff;
                mask_din    = 8'hff;
                @(negedge clock);
            end
            pixel_wr_en = 1'b1;
            pixel_din   = pix_mem[i];
            mask_din    = mask_mem[i];
        end
        @(negedge clock);
        pixel_wr_en = 1'b0;
    endtask

    task automatic wait_frame_done();
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (!frame_done) begin
            cycles++;
            if (cycles > FRAME_BOUND) begin
                report_fail("frame_done did not arrive within the per-frame cycle bound");
            end
            @(negedge clock);
        end
    endtask

    task automatic check_results();
        check_bit("left_valid", left_valid, exp_valid[0]);
        check_theta("left_theta", left_theta, exp_theta[0]);
        check_rho("left_rho", left_rho, exp_rho[0]);
        check_count("left_votes", left_votes, exp_votes[0]);
        check_bit("right_valid", right_valid, exp_valid[1]);
        check_theta("right_theta", right_theta, exp_theta[1]);
        check_rho("right_rho", right_rho, exp_rho[1]);
        check_count("right_votes", right_votes, exp_votes[1]);
    endtask

    task automatic run_frame();
        send_frame(1'b0);
        wait_frame_done();
        model_frame();
        check_results();
    endtask

    task automatic test_reset_state();
        check_bit("pixel_full", pixel_full, 1'b0);
        check_bit("frame_done", frame_done, 1'b0);
        check_bit("left_valid", left_valid, 1'b0);
        check_bit("right_valid", right_valid, 1'b0);
    endtask

    task automatic test_vertical_line();
        fill_frame(8'h00, 8'h01);
        for (int y = 0; y < IMG_H; y++) begin
            set_pixel(5, y, 8'd200, 8'h01);
        end
        run_frame();
        check_bit("left_valid", left_valid, 1'b1);
        check_theta("left_theta", left_theta, '0);
        check_rho("left_rho", left_rho, 7'sd5);
        check_count("left_votes", left_votes, 8'd16);
    endtask

    task automatic test_masked_edges();
        fill_frame(8'hff, 8'h00);
        run_frame();
        check_bit("left_valid", left_valid, 1'b0);
        check_bit("right_valid", right_valid, 1'b0);
        // Just below the edge threshold
        fill_frame(8'd127, 8'hff);
        run_frame();
        check_bit("left_valid", left_valid, 1'b0);
        check_bit("right_valid", right_valid, 1'b0);
    endtask

    task automatic test_two_lines();
        fill_frame(8'h00, 8'h00);
        for (int y = 0; y < IMG_H; y++) begin
            set_pixel(3, y, 8'd180, (y < 12) ? 8'h01 : 8'h00);
            set_pixel(y, y, 8'd250, (y < 12) ? 8'h01 : 8'h00);
        end
        run_frame();
    endtask

    task automatic test_back_to_back();
        fill_frame(8'h00, 8'hff);
        for (int y = 0; y < IMG_H; y++) begin
            set_pixel(10, y, 8'd220, 8'hff);
        end
        send_frame(1'b0);
        fill_frame(8'h00, 8'hff);
        for (int y = 0; y < IMG_H; y++) begin
            set_pixel(IMG_W - 1 - y, y, 8'd140, 8'h80);
        end
        send_frame(1'b1);
        wait_frame_done();
        model_frame();
        check_results();
    endtask

    task automatic test_random_frames();
        for (int f = 0; f < 3; f++) begin
            for (int p = 0; p < PIXELS; p++) begin
                pix_mem[p]  = rand_bits(8);
                mask_mem[p] = rand_bits(1);
            end
            run_frame();
        end
    endtask

    initial begin
        #(WATCHDOG_TIME);
        report_fail("watchdog expired before all frames were processed");
    end

    initial begin
        clock       = 1'b0;
        reset       = 1'b1;
        pixel_wr_en = 1'b0;
        pixel_din   = '0;
        mask_din    = '0;
        lfsr_state  = 32'hb5531d58;
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        test_reset_state();
        test_vertical_line();
        test_masked_edges();
        test_two_lines();
        test_back_to_back();
        test_random_frames();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* dv/hough_tb_sva.sv */
// Hough DUT assertions on the accumulator handshakes and the frame store back-pressure
module hough_tb_sva (
    input logic clock,
    input logic reset,
    input logic vote_req,
    input logic vote_ack,
    input logic pick_req,
    input logic pick_ack,
    input logic pixel_full,
    input logic frame_ready
);

    vote_ack_needs_req: assert property (@(posedge clock) disable iff (reset)
        $rose(vote_ack) |-> vote_req)
        else $error("vote ack rose without a vote request");

    pick_ack_needs_req: assert property (@(posedge clock) disable iff (reset)
        $rose(pick_ack) |-> pick_req)
        else $error("pick ack rose without a pick request");

    // The memory serves one bus at a time
    single_ack: assert property (@(posedge clock) disable iff (reset)
        !(vote_ack && pick_ack))
        else $error("both accumulator acks high together");

    ready_while_open: assert property (@(posedge clock) disable iff (reset)
        frame_ready |-> !$past(pixel_full))
        else $error("frame_ready pulsed while the store was already full");

endmodule

bind accum_arbiter hough_tb_sva arb_sva (
    .clock       (clock),
    .reset       (reset),
    .vote_req    (vote_bus.req),
    .vote_ack    (vote_ack),
    .pick_req    (pick_bus.req),
    .pick_ack    (pick_ack),
    .pixel_full  (1'b0),
    .frame_ready (1'b0)
);

bind edge_frame_store hough_tb_sva store_sva (
    .clock       (clock),
    .reset       (reset),
    .vote_req    (1'b0),
    .vote_ack    (1'b0),
    .pick_req    (1'b0),
    .pick_ack    (1'b0),
    .pixel_full  (pixel_full),
    .frame_ready (frame_ready)
);

/* src/hough_top.sv */
// Hough lane finder top level joining the frame store, voter, picker and accumulator arbiter
module hough_top
    import hough_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  pixel_wr_en,
    input  logic [7:0]            pixel_din,
    input  logic [7:0]            mask_din,
    output logic                  pixel_full,
    output logic                  frame_done,
    output logic                  left_valid,
    output logic [THETA_BITS-1:0] left_theta,
    output logic signed [6:0]     left_rho,
    output logic [COUNT_BITS-1:0] left_votes,
    output logic                  right_valid,
    output logic [THETA_BITS-1:0] right_theta,
    output logic signed [6:0]     right_rho,
    output logic [COUNT_BITS-1:0] right_votes
);

    logic                     frame_ready;
    logic                     vote_done;
    logic                     edge_bit;
    logic [PIX_ADDR_BITS-1:0] rd_addr;

    accum_bus_if vote_bus ();
    accum_bus_if pick_bus ();

    edge_frame_store store0 (
        .clock       (clock),
        .reset       (reset),
        .pixel_wr_en (pixel_wr_en),
        .pixel_din   (pixel_din),
        .mask_din    (mask_din),
        .frame_done  (frame_done),
        .rd_addr     (rd_addr),
        .pixel_full  (pixel_full),
        .frame_ready (frame_ready),
        .edge_bit    (edge_bit)
    );

    hough_voter voter0 (
        .clock       (clock),
        .reset       (reset),
        .frame_ready (frame_ready),
        .edge_bit    (edge_bit),
        .rd_addr     (rd_addr),
        .vote_done   (vote_done),
        .acc         (vote_bus.requester)
    );

    // Frame done also reopens the input stream
    line_picker picker0 (
        .clock       (clock),
        .reset       (reset),
        .vote_done   (vote_done),
        .frame_done  (frame_done),
        .left_valid  (left_valid),
        .left_theta  (left_theta),
        .left_rho    (left_rho),
        .left_votes  (left_votes),
        .right_valid (right_valid),
        .right_theta (right_theta),
        .right_rho   (right_rho),
        .right_votes (right_votes),
        .acc         (pick_bus.requester)
    );

    accum_arbiter arbiter0 (
        .clock    (clock),
        .reset    (reset),
        .vote_bus (vote_bus.arbiter),
        .pick_bus (pick_bus.arbiter)
    );

endmodule

/* src/accum_arbiter.sv */
// Accumulator arbiter that owns the vote memory and serves the voter and the picker in turn
module accum_arbiter
    import hough_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    accum_bus_if.arbiter vote_bus,
    accum_bus_if.arbiter pick_bus
);

    logic [COUNT_BITS-1:0]    acc_mem [ACC_DEPTH];
    logic [COUNT_BITS-1:0]    rd_q;
    logic                     vote_ack;
    logic                     pick_ack;
    logic                     grant_vote;
    logic                     grant_pick;
    logic                     g_write;
    logic [ACC_ADDR_BITS-1:0] g_addr;
    logic [COUNT_BITS-1:0]    g_wdata;

    // New grant only while no bus holds the memory, voter first
    assign grant_vote = !vote_ack && !pick_ack && vote_bus.req;
    assign grant_pick = !vote_ack && !pick_ack && !vote_bus.req && pick_bus.req;

    assign g_write = grant_vote ? vote_bus.write : pick_bus.write;
    assign g_addr  = grant_vote ? vote_bus.addr  : pick_bus.addr;
    assign g_wdata = grant_vote ? vote_bus.wdata : pick_bus.wdata;

    assign vote_bus.ack   = vote_ack;
    assign pick_bus.ack   = pick_ack;
    // Only the acknowledged bus samples the read data
    assign vote_bus.rdata = rd_q;
    assign pick_bus.rdata = rd_q;

    // Ack rises on the grant and holds until the owner drops req
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            vote_ack <= 1'b0;
            pick_ack <= 1'b0;
        end else begin
            if (grant_vote) begin
                vote_ack <= 1'b1;
            end else if (!vote_bus.req) begin
                vote_ack <= 1'b0;
            end
            if (grant_pick) begin
                pick_ack <= 1'b1;
            end else if (!pick_bus.req) begin
                pick_ack <= 1'b0;
            end
        end
    end

    // Memory access happens on the grant edge
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < ACC_DEPTH; i++) begin
                acc_mem[i] <= '0;
            end
            rd_q <= '0;
        end else if (grant_vote || grant_pick) begin
            if (g_write) begin
                acc_mem[g_addr] <= g_wdata;
            end else begin
                rd_q <= acc_mem[g_addr];
            end
        end
    end

endmodule

/* src/line_picker.sv */
// Line picker that scans and clears the accumulator and reports the best left and right lines
module line_picker
    import hough_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    vote_done,
    output logic                    frame_done,
    output logic                    left_valid,
    output logic [THETA_BITS-1:0]   left_theta,
    output logic signed [6:0]       left_rho,
    output logic [COUNT_BITS-1:0]   left_votes,
    output logic                    right_valid,
    output logic [THETA_BITS-1:0]   right_theta,
    output logic signed [6:0]       right_rho,
    output logic [COUNT_BITS-1:0]   right_votes,
    accum_bus_if.requester          acc
);

    enum logic [2:0] {
        S_IDLE,
        S_RD,
        S_RD_END,
        S_WR,
        S_WR_END,
        S_FIN
    } state;

    logic [THETA_BITS-1:0] theta;
    logic [RHO_BITS-1:0]   bin;
    logic                  half;
    // Index 0 holds the left best, index 1 the right best
    logic [COUNT_BITS-1:0] best_cnt   [2];
    logic [THETA_BITS-1:0] best_theta [2];
    logic [RHO_BITS-1:0]   best_bin   [2];

    assign half      = (theta >= LEFT_THETAS);
    assign acc.req   = (state == S_RD) || (state == S_WR);
    assign acc.write = (state == S_WR);
    assign acc.addr  = ACC_ADDR_BITS'(theta * RHO_BINS + bin);
    assign acc.wdata = '0;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state       <= S_IDLE;
            theta       <= '0;
            bin         <= '0;
            frame_done  <= 1'b0;
            left_valid  <= 1'b0;
            right_valid <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (vote_done) begin
                        theta <= '0;
                        bin   <= '0;
                        state <= S_RD;
                    end
                end
                S_RD: begin
                    if (acc.ack) begin
                        state <= S_RD_END;
                    end
                end
                S_RD_END: begin
                    if (!acc.ack) begin
                        state <= S_WR;
                    end
                end
                S_WR: begin
                    if (acc.ack) begin
                        state <= S_WR_END;
                    end
                end
                S_WR_END: begin
                    if (!acc.ack) begin
                        if (bin != RHO_BITS'(RHO_BINS - 1)) begin
                            bin   <= bin + 1'b1;
                            state <= S_RD;
                        end else if (theta != THETA_BITS'(THETAS - 1)) begin
                            bin   <= '0;
                            theta <= theta + 1'b1;
                            state <= S_RD;
                        end else begin
                            state <= S_FIN;
                        end
                    end
                end
                S_FIN: begin
                    frame_done  <= 1'b1;
                    left_valid  <= (best_cnt[0] >= VOTE_THRESHOLD);
                    right_valid <= (best_cnt[1] >= VOTE_THRESHOLD);
                    state       <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Running maxima, only a strictly larger count moves the best
    always_ff @(posedge clock) begin
        if (state == S_IDLE && vote_done) begin
            // Each half starts at its lowest address with zero votes
            best_cnt   <= '{default: '0};
            best_theta <= '{'0, THETA_BITS'(LEFT_THETAS)};
            best_bin   <= '{default: '0};
        end else if (state == S_RD && acc.ack && acc.rdata > best_cnt[half]) begin
            best_cnt[half]   <= acc.rdata;
            best_theta[half] <= theta;
            best_bin[half]   <= bin;
        end
        if (state == S_FIN) begin
            left_theta  <= best_theta[0];
            left_rho    <= 7'($signed({1'b0, best_bin[0]}) - RHO_OFFSET);
            left_votes  <= best_cnt[0];
            right_theta <= best_theta[1];
            right_rho   <= 7'($signed({1'b0, best_bin[1]}) - RHO_OFFSET);
            right_votes <= best_cnt[1];
        end
    end

endmodule

/* src/hough_voter.sv */
// Hough voter that walks the edge frame and increments one accumulator bin per edge pixel and angle
module hough_voter
    import hough_pkg::*;
(
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     frame_ready,
    input  logic                     edge_bit,
    output logic [PIX_ADDR_BITS-1:0] rd_addr,
    output logic                     vote_done,
    accum_bus_if.requester           acc
);

    enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_TEST,
        S_RD,
        S_RD_END,
        S_WR,
        S_WR_END,
        S_NEXT
    } state;

    logic [PIX_ADDR_BITS-1:0] pix;
    logic [THETA_BITS-1:0]    theta;
    logic [COUNT_BITS-1:0]    count_q;
    logic [PIX_ADDR_BITS-1:0] x;
    logic [PIX_ADDR_BITS-1:0] y;
    logic signed [15:0]       rho_sum;
    logic signed [15:0]       rho_floor;
    logic [RHO_BITS-1:0]      rho_bin;

    // Rho for the current pixel and angle
    always_comb begin
        x         = PIX_ADDR_BITS'(pix % IMG_W);
        y         = PIX_ADDR_BITS'(pix / IMG_W);
        rho_sum   = $signed({1'b0, x}) * COS_TABLE[theta]
                  + $signed({1'b0, y}) * SIN_TABLE[theta];
        // Drop the 8 fraction bits, rounding toward minus infinity
        rho_floor = rho_sum >>> 8;
        rho_bin   = RHO_BITS'(rho_floor + RHO_OFFSET);
    end

    assign rd_addr   = pix;
    assign acc.req   = (state == S_RD) || (state == S_WR);
    assign acc.write = (state == S_WR);
    assign acc.addr  = ACC_ADDR_BITS'(theta * RHO_BINS + rho_bin);
    assign acc.wdata = count_q;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state     <= S_IDLE;
            pix       <= '0;
            theta     <= '0;
            vote_done <= 1'b0;
        end else begin
            vote_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (frame_ready) begin
                        pix   <= '0;
                        state <= S_FETCH;
                    end
                end
                // Edge bit for pix is registered at the end of this cycle
                S_FETCH: state <= S_TEST;
                S_TEST: begin
                    theta <= '0;
                    state <= edge_bit ? S_RD : S_NEXT;
                end
                S_RD: begin
                    if (acc.ack) begin
                        state <= S_RD_END;
                    end
                end
                S_RD_END: begin
                    if (!acc.ack) begin
                        state <= S_WR;
                    end
                end
                S_WR: begin
                    if (acc.ack) begin
                        state <= S_WR_END;
                    end
                end
                S_WR_END: begin
                    if (!acc.ack) begin
                        if (theta == THETA_BITS'(THETAS - 1)) begin
                            state <= S_NEXT;
                        end else begin
                            theta <= theta + 1'b1;
                            state <= S_RD;
                        end
                    end
                end
                S_NEXT: begin
                    if (pix == PIX_ADDR_BITS'(PIXELS - 1)) begin
                        vote_done <= 1'b1;
                        state     <= S_IDLE;
                    end else begin
                        pix   <= pix + 1'b1;
                        state <= S_FETCH;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Incremented count, saturating at the top of the range
    always_ff @(posedge clock) begin
        if (state == S_RD && acc.ack) begin
            count_q <= (acc.rdata == '1) ? acc.rdata : acc.rdata + 1'b1;
        end
    end

endmodule

/* src/edge_frame_store.sv */
// Edge frame store that qualifies streamed pixels against threshold and mask and keeps one bit each
module edge_frame_store
    import hough_pkg::*;
(
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     pixel_wr_en,
    input  logic [7:0]               pixel_din,
    input  logic [7:0]               mask_din,
    input  logic                     frame_done,
    input  logic [PIX_ADDR_BITS-1:0] rd_addr,
    output logic                     pixel_full,
    output logic                     frame_ready,
    output logic                     edge_bit
);

    logic                     edge_mem [PIXELS];
    logic [PIX_ADDR_BITS-1:0] wr_count;
    logic                     accept;
    logic                     last_pixel;

    assign accept     = pixel_wr_en && !pixel_full;
    assign last_pixel = (wr_count == PIX_ADDR_BITS'(PIXELS - 1));

    // Pixel counter and input back-pressure
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_count    <= '0;
            pixel_full  <= 1'b0;
            frame_ready <= 1'b0;
        end else begin
            frame_ready <= accept && last_pixel;
            if (accept) begin
                // Wraps back to zero after the last pixel
                wr_count <= wr_count + 1'b1;
            end
            if (accept && last_pixel) begin
                pixel_full <= 1'b1;
            end else if (frame_done) begin
                pixel_full <= 1'b0;
            end
        end
    end

    // One edge bit per raster index, read port registered for the voter
    always_ff @(posedge clock) begin
        if (accept) begin
            edge_mem[wr_count] <= (pixel_din >= EDGE_THRESHOLD) && (mask_din != '0);
        end
        edge_bit <= edge_mem[rd_addr];
    end

endmodule

/* src/accum_bus_if.sv */
// Accumulator access bus between one requester and the arbiter using a four-phase req/ack
interface accum_bus_if
    import hough_pkg::*;
();

    logic                     req;
    logic                     ack;
    logic                     write;
    logic [ACC_ADDR_BITS-1:0] addr;
    logic [COUNT_BITS-1:0]    wdata;
    // Valid while ack is high after a read
    logic [COUNT_BITS-1:0]    rdata;

    modport requester (
        output req, write, addr, wdata,
        input  ack, rdata
    );

    modport arbiter (
        input  req, write, addr, wdata,
        output ack, rdata
    );

endinterface

/* src/hough_pkg.sv */
// Hough lane finder constants covering frame geometry, angle tables and accumulator sizing
package hough_pkg;

    // Frame geometry, raster index is y * IMG_W + x
    localparam int IMG_W         = 16;
    localparam int IMG_H         = 16;
    localparam int PIXELS        = IMG_W * IMG_H;
    localparam int PIX_ADDR_BITS = 8;

    // Angle k is k * 22.5 degrees
    localparam int THETAS      = 8;
    localparam int THETA_BITS  = 3;
    // Angles below this index form the left half
    localparam int LEFT_THETAS = 4;

    // Signed table entries with 8 fraction bits
    localparam int TRIG_BITS = 10;

    localparam logic signed [TRIG_BITS-1:0] COS_TABLE [THETAS] = '{
        10'sd256, 10'sd237, 10'sd181, 10'sd98,
        10'sd0, -10'sd98, -10'sd181, -10'sd237
    };

    localparam logic signed [TRIG_BITS-1:0] SIN_TABLE [THETAS] = '{
        10'sd0, 10'sd98, 10'sd181, 10'sd237,
        10'sd256, 10'sd237, 10'sd181, 10'sd98
    };

    // Floored rho plus this offset is always a valid bin
    localparam int RHO_OFFSET = 24;
    localparam int RHO_BINS   = 48;
    localparam int RHO_BITS   = 6;

    // Accumulator address is theta * RHO_BINS + bin
    localparam int ACC_ADDR_BITS = 9;
    localparam int ACC_DEPTH     = THETAS * RHO_BINS;
    localparam int COUNT_BITS    = 8;

    // Pixel qualification and line reporting limits
    localparam int EDGE_THRESHOLD = 128;
    localparam int VOTE_THRESHOLD = 4;

endpackage
